/* common/mult_pkg.sv */
package mult_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // One machine word per operand
  localparam int OPERAND_W = 32;
  localparam int PRODUCT_W = 2 * OPERAND_W;

  // Recursion stops at the 4x4 array cell
  localparam int BASE_W = 4;

  // Sideband carried alongside each item
  localparam int TAG_W = 8;

  //////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////

  typedef logic [OPERAND_W-1:0] operand_t;
  typedef logic [PRODUCT_W-1:0] product_t;
  typedef logic [TAG_W-1:0]     tag_t;

  //////////////////////////////////////////////////////////////////////
  // Stream payloads
  //////////////////////////////////////////////////////////////////////

  // Request side, two operands and the tag
  typedef struct packed {
    operand_t a;
    operand_t b;
    tag_t     tag;
  } mul_req_t;

  // Response side, full-width product with the tag of its request
  typedef struct packed {
    product_t product;
    tag_t     tag;
  } mul_rsp_t;

endpackage

/* hw/cla_adder.sv */
`timescale 1ns/1ps

module cla_adder
  import mult_pkg::*;
#(
  parameter int W = OPERAND_W
) (
  input  logic [W-1:0] a,
  input  logic [W-1:0] b,
  input  logic         cin,
  output logic [W-1:0] sum,
  output logic         cout
);

  // Per-bit propagate and generate
  logic [W-1:0] p;
  logic [W-1:0] g;

  // Group terms covering bits i down to 0
  logic [W-1:0] grp_g;
  logic [W-1:0] grp_p;

  // Carry into each bit, c[W] is the carry out
  logic [W:0]   c;

  assign p = a ^ b;
  assign g = a & b;

  assign grp_g[0] = g[0];
  assign grp_p[0] = p[0];

  // Prefix of the group generate/propagate terms
  for (genvar i = 1; i < W; i++) begin : g_prefix
    assign grp_g[i] = g[i] | (p[i] & grp_g[i-1]);
    assign grp_p[i] = p[i] & grp_p[i-1];
  end

  assign c[0] = cin;

  // Each carry looks straight back to cin through its group terms
  for (genvar i = 0; i < W; i++) begin : g_carry
    assign c[i+1] = grp_g[i] | (grp_p[i] & cin);
  end

  assign sum  = p ^ c[W-1:0];
  assign cout = c[W];

endmodule

/* hw/mult/mul_base4.sv */
`timescale 1ns/1ps

module mul_base4
  import mult_pkg::*;
(
  input  logic [BASE_W-1:0]   a,
  input  logic [BASE_W-1:0]   b,
  output logic [2*BASE_W-1:0] product
);

  // pp[i][j] = a[i] & b[j], weight i+j
  logic [BASE_W-1:0][BASE_W-1:0] pp;

  // Sum and carry of the twelve full adders
  logic [11:0] fs;
  logic [11:0] fc;

  function automatic logic [1:0] full_add(input logic x, input logic y, input logic z);
    full_add = {(x & y) | (z & (x ^ y)), x ^ y ^ z};
  endfunction

  for (genvar i = 0; i < BASE_W; i++) begin : g_row
    for (genvar j = 0; j < BASE_W; j++) begin : g_col
      assign pp[i][j] = a[i] & b[j];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reduction array, column by column
  //////////////////////////////////////////////////////////////////////

  // Weight 1 and 2
  assign {fc[0], fs[0]}   = full_add(pp[1][0], pp[0][1], 1'b0);
  assign {fc[1], fs[1]}   = full_add(pp[2][0], pp[1][1], fc[0]);
  assign {fc[2], fs[2]}   = full_add(fs[1], pp[0][2], 1'b0);

  // Weight 3
  assign {fc[3], fs[3]}   = full_add(fc[1], fc[2], 1'b0);
  assign {fc[4], fs[4]}   = full_add(fs[3], pp[3][0], pp[2][1]);
  assign {fc[5], fs[5]}   = full_add(fs[4], pp[1][2], pp[0][3]);

  // Weight 4
  assign {fc[6], fs[6]}   = full_add(fc[3], fc[4], fc[5]);
  assign {fc[7], fs[7]}   = full_add(pp[3][1], pp[2][2], pp[1][3]);
  assign {fc[8], fs[8]}   = full_add(fs[6], fs[7], 1'b0);

  // Weight 5 and up
  assign {fc[9], fs[9]}   = full_add(fc[8], fc[7], fc[6]);
  assign {fc[10], fs[10]} = full_add(fs[9], pp[3][2], pp[2][3]);
  assign {fc[11], fs[11]} = full_add(fc[9], fc[10], pp[3][3]);

  assign product = {fc[11], fs[11], fs[10], fs[8], fs[5], fs[2], fs[0], pp[0][0]};

endmodule

/* hw/mult/mul_split.sv */
`timescale 1ns/1ps

module mul_split
  import mult_pkg::*;
#(
  parameter int W = OPERAND_W
) (
  input  logic [W-1:0]   a,
  input  logic [W-1:0]   b,
  output logic [2*W-1:0] product
);

  // Quadrant products, each W bits
  logic [W-1:0]   q_ll;
  logic [W-1:0]   q_lh;
  logic [W-1:0]   q_hl;
  logic [W-1:0]   q_hh;

  // Cross term sum and the carries out of the middle section
  logic [W-1:0]   cross_sum;
  logic           cross_c;
  logic           mid_c;

  // The two carries folded into a small value for the top quarter
  logic [1:0]     fold;
  logic [W/2-1:0] fold_ext;

  //////////////////////////////////////////////////////////////////////
  // Four half-width products
  //////////////////////////////////////////////////////////////////////

  if (W / 2 == BASE_W) begin : g_leaf
    mul_base4 u_ll (
      .a       (a[W/2-1:0]),
      .b       (b[W/2-1:0]),
      .product (q_ll)
    );
    mul_base4 u_lh (
      .a       (a[W/2-1:0]),
      .b       (b[W-1:W/2]),
      .product (q_lh)
    );
    mul_base4 u_hl (
      .a       (a[W-1:W/2]),
      .b       (b[W/2-1:0]),
      .product (q_hl)
    );
    mul_base4 u_hh (
      .a       (a[W-1:W/2]),
      .b       (b[W-1:W/2]),
      .product (q_hh)
    );
  end else begin : g_node
    mul_split #(.W(W / 2)) u_ll (
      .a       (a[W/2-1:0]),
      .b       (b[W/2-1:0]),
      .product (q_ll)
    );
    mul_split #(.W(W / 2)) u_lh (
      .a       (a[W/2-1:0]),
      .b       (b[W-1:W/2]),
      .product (q_lh)
    );
    mul_split #(.W(W / 2)) u_hl (
      .a       (a[W-1:W/2]),
      .b       (b[W/2-1:0]),
      .product (q_hl)
    );
    mul_split #(.W(W / 2)) u_hh (
      .a       (a[W-1:W/2]),
      .b       (b[W-1:W/2]),
      .product (q_hh)
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Combine
  //////////////////////////////////////////////////////////////////////

  // Lowest quarter comes straight from low-low
  assign product[W/2-1:0] = q_ll[W/2-1:0];

  cla_adder #(.W(W)) u_add_cross (
    .a    (q_hl),
    .b    (q_lh),
    .cin  (1'b0),
    .sum  (cross_sum),
    .cout (cross_c)
  );

  // Middle half: cross terms plus upper low-low and lower high-high
  cla_adder #(.W(W)) u_add_mid (
    .a    (cross_sum),
    .b    ({q_hh[W/2-1:0], q_ll[W-1:W/2]}),
    .cin  (1'b0),
    .sum  (product[W+W/2-1:W/2]),
    .cout (mid_c)
  );

  // Both carries sit at weight W+W/2
  cla_adder #(.W(2)) u_add_fold (
    .a    ({1'b0, cross_c}),
    .b    ({1'b0, mid_c}),
    .cin  (1'b0),
    .sum  (fold),
    .cout ()
  );

  assign fold_ext = {{(W/2-2){1'b0}}, fold};

  // Top quarter cannot overflow, so the carry out stays open
  cla_adder #(.W(W / 2)) u_add_high (
    .a    (q_hh[W-1:W/2]),
    .b    (fold_ext),
    .cin  (1'b0),
    .sum  (product[2*W-1:W+W/2]),
    .cout ()
  );

endmodule

/* hw/mult/mul_pipeline.sv */
`timescale 1ns/1ps

module mul_pipeline
  import mult_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  // Request stream
  input  logic     in_valid,
  output logic     in_ready,
  input  mul_req_t in_req,

  // Response stream
  output logic     out_valid,
  input  logic     out_ready,
  output mul_rsp_t out_rsp,

  // Multiplier core, operands out and product back
  output mul_req_t s1_req,
  input  product_t s1_product
);

  logic     s1_valid;
  logic     s2_valid;
  mul_rsp_t s2_rsp;

  // Single enable for both stages
  logic     advance;

  //////////////////////////////////////////////////////////////////////
  // Stall control
  //////////////////////////////////////////////////////////////////////

  // Move on when the output slot is free or being drained
  assign advance  = !s2_valid || out_ready;
  assign in_ready = advance;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= in_valid;
      s2_valid <= s1_valid;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Payload registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (advance) begin
      s1_req         <= in_req;
      // Product from the core joins the tag of the same item
      s2_rsp.product <= s1_product;
      s2_rsp.tag     <= s1_req.tag;
    end
  end

  assign out_valid = s2_valid;
  assign out_rsp   = s2_rsp;

endmodule

/* hw/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit
  import mult_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  input  logic     in_valid,
  output logic     in_ready,
  input  mul_req_t in_req,

  output logic     out_valid,
  input  logic     out_ready,
  output mul_rsp_t out_rsp
);

  // Stage 1 operands and the combinational product
  mul_req_t s1_req;
  product_t s1_product;

  mul_pipeline u_mul_pipeline (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_req     (in_req),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_rsp    (out_rsp),
    .s1_req     (s1_req),
    .s1_product (s1_product)
  );

  // Full-width core, recursion down to the 4x4 cells
  mul_split #(.W(OPERAND_W)) u_mul_split (
    .a       (s1_req.a),
    .b       (s1_req.b),
    .product (s1_product)
  );

endmodule

/* bench/mul_unit_assert.sv */
`timescale 1ns/1ps

module mul_unit_assert
  import mult_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     in_ready,
  input logic     out_valid,
  input logic     out_ready,
  input mul_rsp_t out_rsp
);

  // Stalled response keeps its valid and payload
  property p_rsp_hold;
    @(posedge clk) disable iff (!rst_n)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_rsp));
  endproperty

  property p_reset_quiet;
    @(posedge clk) !rst_n |-> !out_valid;
  endproperty

  // Empty output stage never stalls the input
  property p_ready_when_empty;
    @(posedge clk) disable iff (!rst_n)
      !out_valid |-> in_ready;
  endproperty

  a_rsp_hold: assert property (p_rsp_hold)
    else $error("out_rsp or out_valid changed while the sink stalled");

  a_reset_quiet: assert property (p_reset_quiet)
    else $error("out_valid high during reset");

  a_ready_when_empty: assert property (p_ready_when_empty)
    else $error("in_ready low with out_valid low");

endmodule

bind mul_unit mul_unit_assert u_mul_unit_assert (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_rsp   (out_rsp)
);

/* bench/tb_mul_unit.sv */
`timescale 1ns/1ps

module tb_mul_unit
  import mult_pkg::*;
();

  localparam int N_TABLE  = 16;
  localparam int N_RANDOM = 200;
  localparam int N_TOTAL  = N_TABLE + N_RANDOM;
  localparam int TIMEOUT  = 100;

  // Galois form of x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic     clk;
  logic     rst_n;
  logic     in_valid;
  logic     in_ready;
  mul_req_t in_req;
  logic     out_valid;
  logic     out_ready;
  mul_rsp_t out_rsp;

  // Corner operand pairs as {a, b}
  logic [63:0] corner_tbl [N_TABLE] = '{
    64'h00000000_00000000,
    64'h00000000_FFFFFFFF,
    64'h00000001_00000001,
    64'h00000001_FFFFFFFF,
    64'hFFFFFFFF_FFFFFFFF,
    64'h80000000_80000000,
    64'h80000000_00000001,
    64'h00008000_00010000,
    64'hAAAAAAAA_55555555,
    64'h55555555_55555555,
    64'hAAAAAAAA_AAAAAAAA,
    64'hFFFF0000_0000FFFF,
    64'h0000FFFF_0000FFFF,
    64'hFFFFFFFF_00000002,
    64'h12345678_9ABCDEF0,
    64'h00000080_80000000
  };

  operand_t    stim_a [N_TOTAL];
  operand_t    stim_b [N_TOTAL];
  product_t    stim_p [N_TOTAL];

  logic [31:0] lfsr_state = 32'h3129;
  int          cycle      = 0;
  int          errors     = 0;
  int          checks     = 0;
  bit          timed_out  = 1'b0;

  // Expected responses and their acceptance edges, oldest first
  mul_rsp_t    exp_q [$];
  int          acc_q [$];

  mul_unit u_mul_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_rsp   (out_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // Full-width unsigned product
  function automatic product_t ref_product(input operand_t a, input operand_t b);
    product_t wide_a;
    product_t wide_b;
    wide_a = product_t'(a);
    wide_b = product_t'(b);
    return wide_a * wide_b;
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    int k;
    v = '0;
    for (k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic build_stimulus();
    int k;
    logic [31:0] v;
    for (k = 0; k < N_TABLE; k++) begin
      stim_a[k] = corner_tbl[k][63:32];
      stim_b[k] = corner_tbl[k][31:0];
    end
    for (k = N_TABLE; k < N_TOTAL; k++) begin
      draw_bits(32, v);
      stim_a[k] = v;
      draw_bits(32, v);
      stim_b[k] = v;
    end
    for (k = 0; k < N_TOTAL; k++) begin
      stim_p[k] = ref_product(stim_a[k], stim_b[k]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Source and sink
  //////////////////////////////////////////////////////////////////////

  // Handshakes are sampled at the falling edge, ahead of the transfer edge
  task automatic send_items(input int first, input int last);
    int idx;
    int idle;
    mul_rsp_t exp_rsp;
    for (idx = first; idx < last; idx++) begin
      in_valid   = 1'b1;
      in_req.a   = stim_a[idx];
      in_req.b   = stim_b[idx];
      in_req.tag = tag_t'(idx);
      idle = 0;
      @(negedge clk);
      while (!in_ready && !timed_out) begin
        idle++;
        if (idle > TIMEOUT) begin
          $display("Timeout: item %0d was never accepted", idx);
          timed_out = 1'b1;
        end else begin
          @(negedge clk);
        end
      end
      if (timed_out) break;
      exp_rsp.product = stim_p[idx];
      exp_rsp.tag     = tag_t'(idx);
      exp_q.push_back(exp_rsp);
      acc_q.push_back(cycle);
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
  endtask

  task automatic collect_items(input int count, input bit random_ready);
    int got;
    int idle;
    int prev_edge;
    int acc_edge;
    mul_rsp_t exp_rsp;
    logic [31:0] bit_v;
    got = 0;
    idle = 0;
    prev_edge = -1;
    while (got < count && !timed_out) begin
      if (random_ready) begin
        draw_bits(1, bit_v);
        out_ready = bit_v[0];
      end else begin
        out_ready = 1'b1;
      end
      @(negedge clk);
      if (out_valid && out_ready) begin
        idle = 0;
        assert (exp_q.size() > 0) else begin
          errors++;
          $display("Response with tag %0d arrived with nothing outstanding", out_rsp.tag);
        end
        if (exp_q.size() > 0) begin
          exp_rsp  = exp_q.pop_front();
          acc_edge = acc_q.pop_front();
          check_value($sformatf("tag of response %0d", got),
                      64'(exp_rsp.tag), 64'(out_rsp.tag));
          check_value($sformatf("product of tag %0d", exp_rsp.tag),
                      exp_rsp.product, out_rsp.product);
          if (!random_ready) begin
            check_value($sformatf("latency of tag %0d", exp_rsp.tag),
                        64'd2, 64'(cycle - acc_edge));
            if (prev_edge >= 0) begin
              check_value($sformatf("spacing before tag %0d", exp_rsp.tag),
                          64'd1, 64'(cycle - prev_edge));
            end
            prev_edge = cycle;
          end
        end
        got++;
      end else begin
        idle++;
        if (idle > TIMEOUT) begin
          $display("Timeout: no response for %0d cycles after %0d of %0d items",
                   TIMEOUT, got, count);
          timed_out = 1'b1;
        end
      end
      @(posedge clk);
      #1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_req    = '0;
    out_ready = 1'b0;
    build_stimulus();

    repeat (5) begin
      @(negedge clk);
      check_value("out_valid in reset", 64'd0, 64'(out_valid));
      check_value("in_ready in reset", 64'd1, 64'(in_ready));
    end
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("out_valid after reset", 64'd0, 64'(out_valid));
    check_value("in_ready after reset", 64'd1, 64'(in_ready));
    @(posedge clk);
    #1;

    // Corner table back to back, sink always ready
    fork
      send_items(0, N_TABLE);
      collect_items(N_TABLE, 1'b0);
    join

    // Random operands under random back-pressure
    fork
      send_items(N_TABLE, N_TOTAL);
      collect_items(N_RANDOM, 1'b1);
    join

    if (!timed_out) begin
      @(negedge clk);
      check_value("out_valid after last item", 64'd0, 64'(out_valid));
    end
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("%0d expected responses never arrived", exp_q.size());
    end

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out ? 1 : 0);
    if (errors == 0 && !timed_out) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* verilog.f */
common/mult_pkg.sv
hw/cla_adder.sv
hw/mult/mul_base4.sv
hw/mult/mul_split.sv
hw/mult/mul_pipeline.sv
hw/mul_unit.sv
bench/mul_unit_assert.sv
bench/tb_mul_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the multiplier testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

LOG=sim.log

verilator --binary --timing --assert --top-module tb_mul_unit -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_mul_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
